/* logic/bus_config.svh */
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Address map
////////////////////////////////////////////////////////////////////////////

// Region tag lives in address bits 31:28
`define BUS_REGION_SRAM 4'h0
`define BUS_REGION_DISP 4'hE

////////////////////////////////////////////////////////////////////////////
// Region sizes
////////////////////////////////////////////////////////////////////////////

// SRAM depth in 32-bit words, power of two, 1024 at most
`define BUS_SRAM_WORDS 1024

// Display data channels ahead of select, point and LE registers
`define BUS_DISP_CHANNELS 8

////////////////////////////////////////////////////////////////////////////
// Flow control
////////////////////////////////////////////////////////////////////////////

// Master credits after reset, also the response FIFO depth
`define BUS_REQ_CREDITS 4

// Fabric credits toward the response sink after reset
`define BUS_RESP_CREDITS 2

`endif

/* logic/bus_pkg.sv */
package bus_pkg;

    // Region picked by the address decoder
    typedef enum logic [1:0] {
        REGION_SRAM = 2'd0,
        REGION_DISP = 2'd1,
        REGION_NONE = 2'd2
    } bus_region_e;

    // Response status
    typedef enum logic [1:0] {
        ERR_OK       = 2'd0,
        ERR_UNMAPPED = 2'd1,
        // Display register index out of range
        ERR_BADREG   = 2'd2
    } bus_err_e;

    // One bus address, two decodes
    typedef union packed {
        // Memory view, word index sized for the largest SRAM
        struct packed {
            logic [3:0]  region;
            logic [15:0] unused;
            logic [9:0]  word_idx;
            logic [1:0]  byte_off;
        } mem;
        // Register view, sixteen word registers
        struct packed {
            logic [3:0]  region;
            logic [21:0] unused;
            logic [3:0]  reg_idx;
            logic [1:0]  byte_off;
        } regs;
    } bus_addr_u;

endpackage

/* logic/sram_region.sv */
`timescale 1ns/1ps
`include "bus_config.svh"

module sram_region (
    input  logic                               clk_100mhz,
    input  logic                               we,
    input  logic [$clog2(`BUS_SRAM_WORDS)-1:0] word_addr,
    input  logic [31:0]                        wdata,
    output logic [31:0]                        rdata
);

    localparam int WORDS = `BUS_SRAM_WORDS;

    ////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////

    // Contents undefined until written
    logic [31:0] mem [WORDS];

    // Single port, one access per cycle
    // Write and registered read share the word address
    always_ff @(posedge clk_100mhz) begin
        if (we) begin
            mem[word_addr] <= wdata;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////////////////////////

    // Read-before-write, a same-word write returns the old word
    always_ff @(posedge clk_100mhz) begin
        rdata <= mem[word_addr];
    end

endmodule

/* logic/disp_regs.sv */
`timescale 1ns/1ps
`include "bus_config.svh"

module disp_regs (
    input  logic        clk_100mhz,
    input  logic        arst_n,
    input  logic        we,
    input  logic [3:0]  reg_index,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        reg_bad,
    output logic [31:0] disp_num,
    output logic [7:0]  disp_point,
    output logic [7:0]  disp_le
);

    localparam int CHANNELS = `BUS_DISP_CHANNELS;
    localparam int CH_W     = $clog2(CHANNELS);
    // Control registers follow the data channels
    localparam int SEL_IDX  = CHANNELS;
    localparam int PT_IDX   = CHANNELS + 1;
    localparam int LE_IDX   = CHANNELS + 2;

    logic [31:0]     chan [CHANNELS];
    logic [CH_W-1:0] sel;
    logic [7:0]      point;
    logic [7:0]      le;

    // Anything past the LE mask is a hole
    assign reg_bad = (reg_index > LE_IDX);

    ////////////////////////////////////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_100mhz or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < CHANNELS; i++) begin
                chan[i] <= '0;
            end
            sel   <= '0;
            point <= '0;
            le    <= '0;
        end else if (we) begin
            // Holes fall through, write dropped
            if (reg_index < CHANNELS) begin
                chan[reg_index[CH_W-1:0]] <= wdata;
            end else if (reg_index == SEL_IDX) begin
                sel <= wdata[CH_W-1:0];
            end else if (reg_index == PT_IDX) begin
                point <= wdata[7:0];
            end else if (reg_index == LE_IDX) begin
                le <= wdata[7:0];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Registered read, same latency as SRAM
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_100mhz) begin
        if (reg_index < CHANNELS) begin
            rdata <= chan[reg_index[CH_W-1:0]];
        end else if (reg_index == SEL_IDX) begin
            rdata <= 32'(sel);
        end else if (reg_index == PT_IDX) begin
            rdata <= {24'd0, point};
        end else if (reg_index == LE_IDX) begin
            rdata <= {24'd0, le};
        end else begin
            rdata <= '0;
        end
    end

    // Display side
    assign disp_num   = chan[sel];
    assign disp_point = point;
    assign disp_le    = le;

endmodule

/* logic/req_decode_stage.sv */
`timescale 1ns/1ps
`include "bus_config.svh"

module req_decode_stage (
    input  logic                  clk_100mhz,
    input  logic                  arst_n,
    input  logic                  req_valid,
    input  logic                  req_write,
    input  logic [31:0]           req_addr,
    input  logic [31:0]           req_wdata,
    input  logic                  req_credit,
    output logic                  dec_valid,
    output logic                  dec_write,
    output bus_pkg::bus_region_e  dec_region,
    output bus_pkg::bus_addr_u    dec_addr,
    output logic [31:0]           dec_wdata
);

    import bus_pkg::*;

    localparam int CRED_W = $clog2(`BUS_REQ_CREDITS + 1);

    bus_addr_u         req_view;
    bus_region_e       region_next;
    logic [CRED_W-1:0] master_credits;

    // Tag sits in the same bits in both views
    assign req_view = req_addr;

    always_comb begin
        if (req_view.mem.region == `BUS_REGION_SRAM) begin
            region_next = REGION_SRAM;
        end else if (req_view.mem.region == `BUS_REGION_DISP) begin
            region_next = REGION_DISP;
        end else begin
            region_next = REGION_NONE;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_100mhz or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= req_valid;
        end
    end

    // Payload only loads on an accepted request
    always_ff @(posedge clk_100mhz) begin
        if (req_valid) begin
            dec_write  <= req_write;
            dec_region <= region_next;
            dec_addr   <= req_view;
            dec_wdata  <= req_wdata;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Master credit mirror
    ////////////////////////////////////////////////////////////////////////

    // Spent on each request, returned on each req_credit pulse
    always_ff @(posedge clk_100mhz or negedge arst_n) begin
        if (!arst_n) begin
            master_credits <= CRED_W'(`BUS_REQ_CREDITS);
        end else begin
            case ({req_valid, req_credit})
                2'b10:   master_credits <= master_credits - 1'b1;
                2'b01:   master_credits <= master_credits + 1'b1;
                default: master_credits <= master_credits;
            endcase
        end
    end

    // Master must hold a credit for every request it sends
    assert property (@(posedge clk_100mhz) disable iff (!arst_n)
        req_valid |-> (master_credits != '0));

    // Credit returns never outrun the requests that were issued
    assert property (@(posedge clk_100mhz) disable iff (!arst_n)
        master_credits <= CRED_W'(`BUS_REQ_CREDITS));

endmodule

/* logic/access_stage.sv */
`timescale 1ns/1ps
`include "bus_config.svh"

module access_stage (
    input  logic                 clk_100mhz,
    input  logic                 arst_n,
    input  logic                 dec_valid,
    input  logic                 dec_write,
    input  bus_pkg::bus_region_e dec_region,
    input  bus_pkg::bus_addr_u   dec_addr,
    input  logic [31:0]          dec_wdata,
    output logic                 acc_valid,
    output logic [31:0]          acc_rdata,
    output bus_pkg::bus_err_e    acc_err,
    output logic [31:0]          disp_num,
    output logic [7:0]           disp_point,
    output logic [7:0]           disp_le
);

    import bus_pkg::*;

    localparam int SRAM_AW = $clog2(`BUS_SRAM_WORDS);

    logic        sram_we;
    logic        disp_we;
    logic [31:0] sram_rdata;
    logic [31:0] disp_rdata;
    logic        disp_bad;
    bus_err_e    err_next;
    // Region and direction follow the read data by one cycle
    bus_region_e region_q;
    logic        write_q;

    ////////////////////////////////////////////////////////////////////////
    // Region select
    ////////////////////////////////////////////////////////////////////////

    assign sram_we = dec_valid && dec_write && (dec_region == REGION_SRAM);
    assign disp_we = dec_valid && dec_write && (dec_region == REGION_DISP);

    sram_region i_sram (
        .clk_100mhz (clk_100mhz),
        .we         (sram_we),
        .word_addr  (dec_addr.mem.word_idx[SRAM_AW-1:0]),
        .wdata      (dec_wdata),
        .rdata      (sram_rdata)
    );

    disp_regs i_disp (
        .clk_100mhz (clk_100mhz),
        .arst_n     (arst_n),
        .we         (disp_we),
        .reg_index  (dec_addr.regs.reg_idx),
        .wdata      (dec_wdata),
        .rdata      (disp_rdata),
        .reg_bad    (disp_bad),
        .disp_num   (disp_num),
        .disp_point (disp_point),
        .disp_le    (disp_le)
    );

    always_comb begin
        err_next = ERR_OK;
        if (dec_region == REGION_NONE) begin
            err_next = ERR_UNMAPPED;
        end else if ((dec_region == REGION_DISP) && disp_bad) begin
            err_next = ERR_BADREG;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_100mhz or negedge arst_n) begin
        if (!arst_n) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (dec_valid) begin
            region_q <= dec_region;
            write_q  <= dec_write;
            acc_err  <= err_next;
        end
    end

    // Writes and unmapped space read back as zero
    always_comb begin
        if (write_q) begin
            acc_rdata = '0;
        end else if (region_q == REGION_SRAM) begin
            acc_rdata = sram_rdata;
        end else if (region_q == REGION_DISP) begin
            acc_rdata = disp_rdata;
        end else begin
            acc_rdata = '0;
        end
    end

    // One region written per cycle at most
    assert property (@(posedge clk_100mhz) disable iff (!arst_n)
        !(sram_we && disp_we));

endmodule

/* logic/resp_queue_stage.sv */
`timescale 1ns/1ps
`include "bus_config.svh"

module resp_queue_stage (
    input  logic              clk_100mhz,
    input  logic              arst_n,
    input  logic              acc_valid,
    input  logic [31:0]       acc_rdata,
    input  bus_pkg::bus_err_e acc_err,
    input  logic              resp_credit,
    output logic              resp_valid,
    output logic [31:0]       resp_rdata,
    output bus_pkg::bus_err_e resp_err,
    output logic              req_credit
);

    import bus_pkg::*;

    localparam int DEPTH  = `BUS_REQ_CREDITS;
    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int RCRD_W = $clog2(`BUS_RESP_CREDITS + 1);

    logic [31:0]       data_mem [DEPTH];
    bus_err_e          err_mem  [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [RCRD_W-1:0] resp_credits;
    logic              full;
    logic              pop;

    assign full = (count == CNT_W'(DEPTH));

    // Drain one entry per cycle while the sink has room
    assign pop        = (count != '0) && (resp_credits != '0);
    assign resp_valid = pop;
    assign resp_rdata = data_mem[rd_ptr];
    assign resp_err   = err_mem[rd_ptr];

    // Freed slot goes straight back to the master
    assign req_credit = pop;

    ////////////////////////////////////////////////////////////////////////
    // FIFO
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_100mhz) begin
        if (acc_valid) begin
            data_mem[wr_ptr] <= acc_rdata;
            err_mem[wr_ptr]  <= acc_err;
        end
    end

    always_ff @(posedge clk_100mhz or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (acc_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            if (acc_valid && !pop) begin
                count <= count + 1'b1;
            end else if (!acc_valid && pop) begin
                count <= count - 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Response credits
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_100mhz or negedge arst_n) begin
        if (!arst_n) begin
            resp_credits <= RCRD_W'(`BUS_RESP_CREDITS);
        end else begin
            case ({pop, resp_credit})
                2'b10:   resp_credits <= resp_credits - 1'b1;
                2'b01:   resp_credits <= resp_credits + 1'b1;
                default: resp_credits <= resp_credits;
            endcase
        end
    end

    // Request credit loop keeps occupancy within depth
    assert property (@(posedge clk_100mhz) disable iff (!arst_n)
        acc_valid |-> !full);

    // Sink never returns more than it was given
    assert property (@(posedge clk_100mhz) disable iff (!arst_n)
        resp_credits <= RCRD_W'(`BUS_RESP_CREDITS));

endmodule

/* logic/bus_fabric_top.sv */
`timescale 1ns/1ps

module bus_fabric_top (
    input  logic              clk_100mhz,
    input  logic              arst_n,
    input  logic              req_valid,
    input  logic              req_write,
    input  logic [31:0]       req_addr,
    input  logic [31:0]       req_wdata,
    output logic              req_credit,
    output logic              resp_valid,
    output logic [31:0]       resp_rdata,
    output bus_pkg::bus_err_e resp_err,
    input  logic              resp_credit,
    output logic [31:0]       disp_num,
    output logic [7:0]        disp_point,
    output logic [7:0]        disp_le
);

    import bus_pkg::*;

    // Decode to access
    logic        dec_valid;
    logic        dec_write;
    bus_region_e dec_region;
    bus_addr_u   dec_addr;
    logic [31:0] dec_wdata;

    // Access to response queue
    logic        acc_valid;
    logic [31:0] acc_rdata;
    bus_err_e    acc_err;

    ////////////////////////////////////////////////////////////////////////
    // Pipeline
    ////////////////////////////////////////////////////////////////////////

    req_decode_stage i_decode (
        .clk_100mhz (clk_100mhz),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_credit (req_credit),
        .dec_valid  (dec_valid),
        .dec_write  (dec_write),
        .dec_region (dec_region),
        .dec_addr   (dec_addr),
        .dec_wdata  (dec_wdata)
    );

    // SRAM and display registers live inside
    access_stage i_access (
        .clk_100mhz (clk_100mhz),
        .arst_n     (arst_n),
        .dec_valid  (dec_valid),
        .dec_write  (dec_write),
        .dec_region (dec_region),
        .dec_addr   (dec_addr),
        .dec_wdata  (dec_wdata),
        .acc_valid  (acc_valid),
        .acc_rdata  (acc_rdata),
        .acc_err    (acc_err),
        .disp_num   (disp_num),
        .disp_point (disp_point),
        .disp_le    (disp_le)
    );

    resp_queue_stage i_resp (
        .clk_100mhz  (clk_100mhz),
        .arst_n      (arst_n),
        .acc_valid   (acc_valid),
        .acc_rdata   (acc_rdata),
        .acc_err     (acc_err),
        .resp_credit (resp_credit),
        .resp_valid  (resp_valid),
        .resp_rdata  (resp_rdata),
        .resp_err    (resp_err),
        .req_credit  (req_credit)
    );

endmodule

/* verification/tb_bus_fabric.sv */
`timescale 1ns/1ps
`include "bus_config.svh"

module tb_bus_fabric;

    import bus_pkg::*;

    localparam string CASE_FILE = "verification/bus_cases.txt";
    localparam int    CH_W      = $clog2(`BUS_DISP_CHANNELS);

    logic        clk_100mhz;
    logic        arst_n;
    logic        req_valid;
    logic        req_write;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic        req_credit;
    logic        resp_valid;
    logic [31:0] resp_rdata;
    bus_err_e    resp_err;
    logic        resp_credit;
    logic [31:0] disp_num;
    logic [7:0]  disp_point;
    logic [7:0]  disp_le;

    // Cases as read from the file
    logic [3:0]  case_op    [$];
    logic [31:0] case_addr  [$];
    logic [31:0] case_wdata [$];
    logic [31:0] case_rdata [$];
    logic [1:0]  case_err   [$];
    int          n_cases;
    int          case_idx;
    bit          loaded;

    // Expected responses in request order
    logic [31:0] exp_data_q [$];
    logic [1:0]  exp_err_q  [$];
    int          accept_cyc_q [$];

    int     cyc;
    int     master_credits;
    int     fabric_credits;
    int     outstanding;
    int     credit_due_q [$];
    integer seed;

    // Display register model
    logic [31:0]     m_chan [`BUS_DISP_CHANNELS];
    logic [CH_W-1:0] m_sel;
    logic [7:0]      m_point;
    logic [7:0]      m_le;

    bus_fabric_top i_dut (
        .clk_100mhz  (clk_100mhz),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req_write   (req_write),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_credit  (req_credit),
        .resp_valid  (resp_valid),
        .resp_rdata  (resp_rdata),
        .resp_err    (resp_err),
        .resp_credit (resp_credit),
        .disp_num    (disp_num),
        .disp_point  (disp_point),
        .disp_le     (disp_le)
    );

    initial begin
        clk_100mhz = 1'b0;
        forever #5 clk_100mhz = ~clk_100mhz;
    end

    ////////////////////////////////////////////////////////////////////////
    // Error reporting
    ////////////////////////////////////////////////////////////////////////

    task automatic value_fail(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, expected);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic event_fail(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Case file
    ////////////////////////////////////////////////////////////////////////

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [3:0]  op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [1:0]  err;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            event_fail("cannot open the case file");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            // Lines starting with a hash are comments
            if (n > 0 && line.getc(0) != 8'h23) begin
                if ($sscanf(line, "%h %h %h %h %h", op, addr, wdata, rdata, err) == 5) begin
                    case_op.push_back(op);
                    case_addr.push_back(addr);
                    case_wdata.push_back(wdata);
                    case_rdata.push_back(rdata);
                    case_err.push_back(err);
                end
            end
        end
        $fclose(fd);
        n_cases = case_op.size();
        if (n_cases == 0) begin
            event_fail("the case file holds no cases");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////

    // Tag E selects display registers with the index in bits 5:2
    task automatic model_write(input logic [31:0] addr, input logic [31:0] wdata);
        logic [3:0] idx;
        idx = addr[5:2];
        if (addr[31:28] == `BUS_REGION_DISP) begin
            if (idx < `BUS_DISP_CHANNELS) begin
                m_chan[idx[CH_W-1:0]] = wdata;
            end else if (idx == `BUS_DISP_CHANNELS) begin
                m_sel = wdata[CH_W-1:0];
            end else if (idx == `BUS_DISP_CHANNELS + 1) begin
                m_point = wdata[7:0];
            end else if (idx == `BUS_DISP_CHANNELS + 2) begin
                m_le = wdata[7:0];
            end
        end
    endtask

    task automatic check_display();
        assert (disp_num == m_chan[m_sel])
            else value_fail("disp_num", disp_num, m_chan[m_sel]);
        assert (disp_point == m_point)
            else value_fail("disp_point", {24'd0, disp_point}, {24'd0, m_point});
        assert (disp_le == m_le)
            else value_fail("disp_le", {24'd0, disp_le}, {24'd0, m_le});
    endtask

    // Quiet outputs between reset and the first request
    task automatic check_idle();
        assert (resp_valid == 1'b0)
            else value_fail("resp_valid", {31'd0, resp_valid}, 32'd0);
        assert (req_credit == 1'b0)
            else value_fail("req_credit", {31'd0, req_credit}, 32'd0);
        check_display();
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Per-cycle steps
    ////////////////////////////////////////////////////////////////////////

    task automatic observe();
        logic [31:0] exp_d;
        logic [1:0]  exp_e;
        int          acc;
        int          due;
        // Freed slot returns with its response
        assert (req_credit == resp_valid)
            else event_fail("req_credit and resp_valid are out of step");
        if (resp_valid) begin
            assert (exp_data_q.size() != 0)
                else event_fail("response with no request outstanding");
            assert (fabric_credits > 0)
                else event_fail("response sent without a response credit");
            exp_d = exp_data_q.pop_front();
            exp_e = exp_err_q.pop_front();
            acc   = accept_cyc_q.pop_front();
            assert (cyc - acc >= 3)
                else event_fail("response came less than three cycles after acceptance");
            assert (resp_rdata == exp_d)
                else value_fail("resp_rdata", resp_rdata, exp_d);
            assert (resp_err == exp_e)
                else value_fail("resp_err", {30'd0, resp_err}, {30'd0, exp_e});
            fabric_credits--;
            outstanding--;
            // Sink consumes after 0 to 5 cycles with one credit pulse per cycle
            due = cyc + int'($unsigned($random(seed)) % 6);
            if (credit_due_q.size() != 0 && due <= credit_due_q[$]) begin
                due = credit_due_q[$] + 1;
            end
            credit_due_q.push_back(due);
        end
        if (resp_credit) begin
            fabric_credits++;
        end
        if (req_credit) begin
            master_credits++;
        end
        assert (master_credits <= `BUS_REQ_CREDITS)
            else event_fail("more request credits returned than were spent");
    endtask

    task automatic drive_sink();
        resp_credit <= 1'b0;
        if (credit_due_q.size() != 0 && credit_due_q[0] <= cyc) begin
            void'(credit_due_q.pop_front());
            resp_credit <= 1'b1;
        end
    endtask

    task automatic issue_case();
        logic [3:0] op;
        req_valid <= 1'b0;
        if (case_idx < n_cases) begin
            op = case_op[case_idx];
            if (op == 4'd2) begin
                // Display check once every earlier write has answered
                if (outstanding == 0) begin
                    check_display();
                    case_idx++;
                end
            end else if (master_credits > 0) begin
                req_valid <= 1'b1;
                req_write <= (op == 4'd1);
                req_addr  <= case_addr[case_idx];
                req_wdata <= case_wdata[case_idx];
                master_credits--;
                outstanding++;
                exp_data_q.push_back(case_rdata[case_idx]);
                exp_err_q.push_back(case_err[case_idx]);
                // Accepted on the next edge
                accept_cyc_q.push_back(cyc + 1);
                if (op == 4'd1) begin
                    model_write(case_addr[case_idx], case_wdata[case_idx]);
                end
                case_idx++;
                assert (outstanding <= `BUS_REQ_CREDITS)
                    else event_fail("more requests outstanding than credits allow");
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////

    initial begin
        arst_n         = 1'b0;
        req_valid      = 1'b0;
        req_write      = 1'b0;
        req_addr       = '0;
        req_wdata      = '0;
        resp_credit    = 1'b0;
        seed           = 32'haaf882f5;
        cyc            = 0;
        case_idx       = 0;
        outstanding    = 0;
        master_credits = `BUS_REQ_CREDITS;
        fabric_credits = `BUS_RESP_CREDITS;
        for (int i = 0; i < `BUS_DISP_CHANNELS; i++) begin
            m_chan[i] = '0;
        end
        m_sel   = '0;
        m_point = '0;
        m_le    = '0;
        load_cases();
        loaded = 1'b1;
        repeat (16) @(posedge clk_100mhz);
        arst_n <= 1'b1;
        repeat (4) begin
            @(posedge clk_100mhz);
            check_idle();
        end
        // Run until every case is done and every credit is back
        while (case_idx < n_cases || exp_data_q.size() != 0 ||
               credit_due_q.size() != 0 || fabric_credits != `BUS_RESP_CREDITS) begin
            @(posedge clk_100mhz);
            cyc++;
            observe();
            drive_sink();
            issue_case();
        end
        $display("Simulation PASSED");
        $finish;
    end

    // Watchdog of 40 cycles per case plus slack
    initial begin
        wait (loaded);
        repeat (16 + n_cases * 40 + 200) @(posedge clk_100mhz);
        $display("ERROR at %0t ns: watchdog expired with %0d of %0d cases issued",
                 $time, case_idx, n_cases);
        $display("Simulation FAILED");
        $fatal(1, "watchdog timeout");
    end

endmodule

/* verification/bus_cases.txt */
# op (0 read, 1 write, 2 drain then check display outputs), address, write data,
# expected read data, expected error (0 ok, 1 unmapped, 2 bad register); all hex
1 00000000 11112222 00000000 0
1 00000004 33334444 00000000 0
1 00000ffc deadbeef 00000000 0
0 00000000 00000000 11112222 0
1 00000008 55556666 00000000 0
0 00000004 00000000 33334444 0
0 00000ffc 00000000 deadbeef 0
0 00000008 00000000 55556666 0
1 00000004 0badf00d 00000000 0
0 00000004 00000000 0badf00d 0
1 e0000000 a0a0a0a0 00000000 0
1 e0000008 c2c2c2c2 00000000 0
1 e000001c f7f7f7f7 00000000 0
1 e0000020 00000002 00000000 0
2 00000000 00000000 00000000 0
0 e0000008 00000000 c2c2c2c2 0
1 e0000024 000000a5 00000000 0
1 e0000028 0000003c 00000000 0
0 e0000024 00000000 000000a5 0
0 e0000028 00000000 0000003c 0
0 e0000020 00000000 00000002 0
1 e0000020 0000000f 00000000 0
2 00000000 00000000 00000000 0
1 40000000 12345678 00000000 1
0 f0000010 00000000 00000000 1
0 10000000 00000000 00000000 1
1 e000002c ffffffff 00000000 2
0 e000003c 00000000 00000000 2
1 e0000034 55555555 00000000 2
0 e0000000 00000000 a0a0a0a0 0
0 e000001c 00000000 f7f7f7f7 0
2 00000000 00000000 00000000 0

/* src.f */
+incdir+logic
logic/bus_pkg.sv
logic/sram_region.sv
logic/disp_regs.sv
logic/req_decode_stage.sv
logic/access_stage.sv
logic/resp_queue_stage.sv
logic/bus_fabric_top.sv
verification/tb_bus_fabric.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bus fabric testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_bus_fabric -f src.f \
    > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_bus_fabric > sim.log 2>&1
cat sim.log

grep -q "^Simulation PASSED$" sim.log && exit 0 || exit 1
